/* verilog/cpu_pkg.sv */
package cpu_pkg;

  //////////////////////////////////////////////////
  // Basic types

  typedef logic [15:0] word_t;     // Data or instruction word
  typedef logic [15:0] addr_t;     // Word address into either memory
  typedef logic [2:0]  reg_idx_t;  // One of the eight general registers
  typedef logic [3:0]  opcode_t;   // Instruction opcode in the low nibble

  //////////////////////////////////////////////////
  // Opcodes

  localparam opcode_t OP_MV   = 4'd0;   // rx = ry
  localparam opcode_t OP_ADD  = 4'd1;   // rx = rx + ry
  localparam opcode_t OP_SUB  = 4'd2;   // rx = rx - ry
  localparam opcode_t OP_CMP  = 4'd3;   // Flags from rx - ry
  localparam opcode_t OP_LD   = 4'd4;   // rx = mem[ry]
  localparam opcode_t OP_ST   = 4'd5;   // mem[ry] = rx
  localparam opcode_t OP_MVI  = 4'd6;   // rx = imm
  localparam opcode_t OP_ADDI = 4'd7;   // rx = rx + imm
  localparam opcode_t OP_J    = 4'd8;   // pc = pc + imm
  localparam opcode_t OP_JZ   = 4'd9;   // Taken when Z is set
  localparam opcode_t OP_JN   = 4'd10;  // Taken when N is set
  localparam opcode_t OP_JR   = 4'd11;  // pc = rx
  localparam opcode_t OP_HALT = 4'd15;

  //////////////////////////////////////////////////
  // Instruction fields

  localparam int OPC_LSB = 0;
  localparam int RX_LSB  = 5;
  localparam int RY_LSB  = 8;
  localparam int IMM_LSB = 8;   // Immediate overlaps the ry field
  localparam int IMM_W   = 8;

  localparam word_t NOP_INSTR = 16'h0000;  // Encodes mv r0,r0
  localparam addr_t RESET_PC  = 16'h0000;
  localparam int    NUM_REGS  = 8;

  //////////////////////////////////////////////////
  // Datapath selects

  localparam logic [1:0] ALU_ADD  = 2'd0;
  localparam logic [1:0] ALU_SUB  = 2'd1;
  localparam logic [1:0] ALU_PASS = 2'd2;  // Result is operand b

  localparam logic [1:0] PC_SEL_SEQ = 2'd0;  // Next sequential word
  localparam logic [1:0] PC_SEL_IMM = 2'd1;  // Decode pc plus immediate
  localparam logic [1:0] PC_SEL_REG = 2'd2;  // Register x from execute

  typedef enum logic [1:0] {
    SEQ_RUN,
    SEQ_DRAIN,
    SEQ_HALTED
  } seq_state_t;

endpackage

/* verilog/cpu_regfile.sv */
`timescale 1ns/10ps

module cpu_regfile (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  cpu_pkg::reg_idx_t i_raddr_x,
  input  cpu_pkg::reg_idx_t i_raddr_y,
  input  cpu_pkg::reg_idx_t i_waddr,
  input  cpu_pkg::word_t    i_wdata,
  input  logic              i_we,
  output cpu_pkg::word_t    o_rdata_x,
  output cpu_pkg::word_t    o_rdata_y
);

  import cpu_pkg::*;

  word_t regs [NUM_REGS];

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // A write in this cycle is seen by the readers straight away
  assign o_rdata_x = (i_we && (i_waddr == i_raddr_x)) ? i_wdata : regs[i_raddr_x];
  assign o_rdata_y = (i_we && (i_waddr == i_raddr_y)) ? i_wdata : regs[i_raddr_y];

endmodule

/* verilog/cpu_control.sv */
`timescale 1ns/10ps

module cpu_control (
  input  logic           i_clk,
  input  logic           i_rst_n,

  // From datapath
  input  cpu_pkg::word_t i_ir_dc,
  input  cpu_pkg::word_t i_ir_ex,
  input  cpu_pkg::word_t i_ir_wr,
  input  logic           i_alu_n,
  input  logic           i_alu_z,
  input  logic           i_alu_n_imm,
  input  logic           i_alu_z_imm,

  // Program counter and memory strobes
  output logic           o_pc_ld,
  output logic [1:0]     o_pc_sel,
  output logic           o_imem_rd,
  output logic           o_ldst_rd,
  output logic           o_ldst_wr,

  // Squash
  output logic           o_ir_dc_squash,
  output logic           o_ir_ex_squash,

  // ALU and flags
  output logic [1:0]     o_alu_op_sel,
  output logic           o_alu_b_imm,
  output logic           o_alu_r_ld,
  output logic           o_flags_ld,

  // Writeback and status
  output logic           o_rf_write,
  output logic           o_rf_wr_mem,
  output logic           o_halted
);

  import cpu_pkg::*;

  opcode_t    op_dc;
  opcode_t    op_ex;
  opcode_t    op_wr;
  logic       flag_src_ex;  // Execute instruction is producing new flags
  logic       flag_n;
  logic       flag_z;
  logic       de_taken;
  logic       de_jump_i;
  logic       ex_jump_r;
  logic       halt_dc;
  logic       running;
  seq_state_t state;
  seq_state_t state_nxt;

  // The all-zero word changes nothing so it is not treated as a write
  function automatic logic writes_rx(input word_t ir);
    opcode_t op;
    op = ir[OPC_LSB +: $bits(opcode_t)];
    return (ir != NOP_INSTR) &&
           (op inside {OP_MV, OP_ADD, OP_SUB, OP_LD, OP_MVI, OP_ADDI});
  endfunction

  assign op_dc = i_ir_dc[OPC_LSB +: $bits(opcode_t)];
  assign op_ex = i_ir_ex[OPC_LSB +: $bits(opcode_t)];
  assign op_wr = i_ir_wr[OPC_LSB +: $bits(opcode_t)];

  //////////////////////////////////////////////////
  // Jump detection

  assign flag_src_ex = op_ex inside {OP_ADD, OP_SUB, OP_CMP, OP_ADDI};
  assign flag_n      = flag_src_ex ? i_alu_n_imm : i_alu_n;  // Forward from execute
  assign flag_z      = flag_src_ex ? i_alu_z_imm : i_alu_z;

  always_comb begin
    case (op_dc)
      OP_J:    de_taken = 1'b1;
      OP_JZ:   de_taken = flag_z;
      OP_JN:   de_taken = flag_n;
      default: de_taken = 1'b0;
    endcase
  end

  assign ex_jump_r = (op_ex == OP_JR);
  assign de_jump_i = de_taken & ~ex_jump_r;              // A jr in execute wins
  assign halt_dc   = (op_dc == OP_HALT) & ~ex_jump_r;    // Wrong-path halt is ignored

  //////////////////////////////////////////////////
  // Halt sequencer

  always_comb begin
    state_nxt = state;
    case (state)
      SEQ_RUN: begin
        if (halt_dc) begin
          state_nxt = SEQ_DRAIN;
        end
      end
      SEQ_DRAIN: begin
        if (op_wr == OP_HALT) begin
          state_nxt = SEQ_HALTED;
        end
      end
      default: state_nxt = SEQ_HALTED;  // Only reset leaves this state
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state <= SEQ_RUN;
    end else begin
      state <= state_nxt;
    end
  end

  // Fetching stops in the very cycle halt sits in decode
  assign running = (state == SEQ_RUN) & ~halt_dc;

  //////////////////////////////////////////////////
  // Fetch and decode strobes

  assign o_imem_rd = running;
  assign o_pc_ld   = running;
  assign o_pc_sel  = ex_jump_r ? PC_SEL_REG : (de_jump_i ? PC_SEL_IMM : PC_SEL_SEQ);

  assign o_ir_dc_squash = de_jump_i | ex_jump_r | ~running;  // Word in flight is dropped
  assign o_ir_ex_squash = ex_jump_r;

  //////////////////////////////////////////////////
  // Execute strobes

  always_comb begin
    case (op_ex)
      OP_SUB, OP_CMP: o_alu_op_sel = ALU_SUB;
      OP_MV, OP_MVI:  o_alu_op_sel = ALU_PASS;
      default:        o_alu_op_sel = ALU_ADD;
    endcase
  end

  assign o_alu_b_imm = op_ex inside {OP_MVI, OP_ADDI};
  assign o_alu_r_ld  = writes_rx(i_ir_ex) & (op_ex != OP_LD);
  assign o_flags_ld  = flag_src_ex;
  assign o_ldst_rd   = (op_ex == OP_LD);
  assign o_ldst_wr   = (op_ex == OP_ST);

  // Writeback strobes
  assign o_rf_write  = writes_rx(i_ir_wr);
  assign o_rf_wr_mem = (op_wr == OP_LD);   // Load data arrives this cycle
  assign o_halted    = (state == SEQ_HALTED);

endmodule

/* verilog/cpu_datapath.sv */
`timescale 1ns/10ps

module cpu_datapath (
  input  logic              i_clk,
  input  logic              i_rst_n,

  // Control strobes
  input  logic              i_pc_ld,
  input  logic [1:0]        i_pc_sel,
  input  logic              i_ir_dc_squash,
  input  logic              i_ir_ex_squash,
  input  logic [1:0]        i_alu_op_sel,
  input  logic              i_alu_b_imm,
  input  logic              i_alu_r_ld,
  input  logic              i_flags_ld,
  input  logic              i_rf_write,
  input  logic              i_rf_wr_mem,

  // Memory returns
  input  cpu_pkg::word_t    i_imem_rdata,
  input  cpu_pkg::word_t    i_dmem_rdata,

  // Register file reads
  input  cpu_pkg::word_t    i_rf_rdata_x,
  input  cpu_pkg::word_t    i_rf_rdata_y,

  // To control
  output cpu_pkg::word_t    o_ir_dc,
  output cpu_pkg::word_t    o_ir_ex,
  output cpu_pkg::word_t    o_ir_wr,
  output logic              o_alu_n,
  output logic              o_alu_z,
  output logic              o_alu_n_imm,
  output logic              o_alu_z_imm,

  // Instruction address
  output cpu_pkg::addr_t    o_pc,

  // Register file
  output cpu_pkg::reg_idx_t o_rf_raddr_x,
  output cpu_pkg::reg_idx_t o_rf_raddr_y,
  output cpu_pkg::reg_idx_t o_rf_waddr,
  output cpu_pkg::word_t    o_rf_wdata,

  // Data memory
  output cpu_pkg::addr_t    o_dmem_addr,
  output cpu_pkg::word_t    o_dmem_wdata
);

  import cpu_pkg::*;

  addr_t pc;
  addr_t pc_dc;      // Address of the word now in decode
  addr_t pc_nxt;
  logic  dc_valid;   // Memory output holds a live fetch
  word_t ir_dc;
  word_t ir_ex;
  word_t ir_wr;
  word_t imm_dc;
  word_t imm_ex;
  word_t opnd_x;
  word_t opnd_y;
  word_t alu_b;
  word_t alu_res;
  word_t alu_r;
  logic  fwd_x;
  logic  fwd_y;
  logic  flag_n;
  logic  flag_z;

  function automatic word_t sext_imm(input word_t ir);
    logic [IMM_W-1:0] imm;
    imm = ir[IMM_LSB +: IMM_W];
    return {{($bits(word_t) - IMM_W){imm[IMM_W-1]}}, imm};
  endfunction

  //////////////////////////////////////////////////
  // Fetch

  assign imm_dc = sext_imm(ir_dc);

  always_comb begin
    case (i_pc_sel)
      PC_SEL_IMM: pc_nxt = pc_dc + imm_dc;  // Relative to the jump itself
      PC_SEL_REG: pc_nxt = opnd_x;
      default:    pc_nxt = pc + 16'd1;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      pc       <= RESET_PC;
      dc_valid <= 1'b0;
    end else begin
      if (i_pc_ld) begin
        pc <= pc_nxt;
      end
      dc_valid <= ~i_ir_dc_squash;
    end
  end

  always_ff @(posedge i_clk) begin
    pc_dc <= pc;
  end

  // The memory read register acts as the decode instruction register
  assign ir_dc = dc_valid ? i_imem_rdata : NOP_INSTR;

  //////////////////////////////////////////////////
  // Stage instruction registers

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ir_ex <= NOP_INSTR;
      ir_wr <= NOP_INSTR;
    end else begin
      ir_ex <= i_ir_ex_squash ? NOP_INSTR : ir_dc;
      ir_wr <= ir_ex;
    end
  end

  //////////////////////////////////////////////////
  // Execute

  assign o_rf_raddr_x = ir_ex[RX_LSB +: $bits(reg_idx_t)];
  assign o_rf_raddr_y = ir_ex[RY_LSB +: $bits(reg_idx_t)];

  // Writeback result bypasses into the execute operands
  assign fwd_x  = i_rf_write && (o_rf_waddr == o_rf_raddr_x);
  assign fwd_y  = i_rf_write && (o_rf_waddr == o_rf_raddr_y);
  assign opnd_x = fwd_x ? o_rf_wdata : i_rf_rdata_x;
  assign opnd_y = fwd_y ? o_rf_wdata : i_rf_rdata_y;

  assign imm_ex = sext_imm(ir_ex);
  assign alu_b  = i_alu_b_imm ? imm_ex : opnd_y;

  always_comb begin
    case (i_alu_op_sel)
      ALU_SUB:  alu_res = opnd_x - alu_b;
      ALU_PASS: alu_res = alu_b;        // mv and mvi
      default:  alu_res = opnd_x + alu_b;
    endcase
  end

  assign o_alu_n_imm = alu_res[$bits(word_t)-1];
  assign o_alu_z_imm = (alu_res == '0);

  always_ff @(posedge i_clk) begin
    if (i_alu_r_ld) begin
      alu_r <= alu_res;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      flag_n <= 1'b0;
      flag_z <= 1'b0;
    end else if (i_flags_ld) begin
      flag_n <= o_alu_n_imm;
      flag_z <= o_alu_z_imm;
    end
  end

  // Address comes from ry and store data from rx
  assign o_dmem_addr  = opnd_y;
  assign o_dmem_wdata = opnd_x;

  //////////////////////////////////////////////////
  // Writeback

  assign o_rf_waddr = ir_wr[RX_LSB +: $bits(reg_idx_t)];
  assign o_rf_wdata = i_rf_wr_mem ? i_dmem_rdata : alu_r;

  assign o_ir_dc = ir_dc;
  assign o_ir_ex = ir_ex;
  assign o_ir_wr = ir_wr;
  assign o_alu_n = flag_n;
  assign o_alu_z = flag_z;
  assign o_pc    = pc;

endmodule

/* verilog/cpu_top.sv */
`timescale 1ns/10ps

module cpu_top (
  input  logic           i_clk,
  input  logic           i_rst_n,

  // Instruction memory
  output logic           o_imem_rd,
  output cpu_pkg::addr_t o_imem_addr,
  input  cpu_pkg::word_t i_imem_rdata,

  // Data memory
  output logic           o_dmem_rd,
  output logic           o_dmem_wr,
  output cpu_pkg::addr_t o_dmem_addr,
  output cpu_pkg::word_t o_dmem_wdata,
  input  cpu_pkg::word_t i_dmem_rdata,

  output logic           o_halted
);

  import cpu_pkg::*;

  word_t      ir_dc;
  word_t      ir_ex;
  word_t      ir_wr;
  logic       alu_n;
  logic       alu_z;
  logic       alu_n_imm;
  logic       alu_z_imm;
  logic       pc_ld;
  logic [1:0] pc_sel;
  logic       ir_dc_squash;
  logic       ir_ex_squash;
  logic [1:0] alu_op_sel;
  logic       alu_b_imm;
  logic       alu_r_ld;
  logic       flags_ld;
  logic       rf_write;
  logic       rf_wr_mem;
  reg_idx_t   rf_raddr_x;
  reg_idx_t   rf_raddr_y;
  reg_idx_t   rf_waddr;
  word_t      rf_wdata;
  word_t      rf_rdata_x;
  word_t      rf_rdata_y;

  //////////////////////////////////////////////////
  // Pipeline control

  cpu_control m_cpu_control (
    .i_clk,
    .i_rst_n,
    .i_ir_dc        (ir_dc),
    .i_ir_ex        (ir_ex),
    .i_ir_wr        (ir_wr),
    .i_alu_n        (alu_n),
    .i_alu_z        (alu_z),
    .i_alu_n_imm    (alu_n_imm),
    .i_alu_z_imm    (alu_z_imm),
    .o_pc_ld        (pc_ld),
    .o_pc_sel       (pc_sel),
    .o_imem_rd,
    .o_ldst_rd      (o_dmem_rd),
    .o_ldst_wr      (o_dmem_wr),
    .o_ir_dc_squash (ir_dc_squash),
    .o_ir_ex_squash (ir_ex_squash),
    .o_alu_op_sel   (alu_op_sel),
    .o_alu_b_imm    (alu_b_imm),
    .o_alu_r_ld     (alu_r_ld),
    .o_flags_ld     (flags_ld),
    .o_rf_write     (rf_write),
    .o_rf_wr_mem    (rf_wr_mem),
    .o_halted
  );

  //////////////////////////////////////////////////
  // Datapath and register file

  cpu_datapath m_cpu_datapath (
    .i_clk,
    .i_rst_n,
    .i_pc_ld        (pc_ld),
    .i_pc_sel       (pc_sel),
    .i_ir_dc_squash (ir_dc_squash),
    .i_ir_ex_squash (ir_ex_squash),
    .i_alu_op_sel   (alu_op_sel),
    .i_alu_b_imm    (alu_b_imm),
    .i_alu_r_ld     (alu_r_ld),
    .i_flags_ld     (flags_ld),
    .i_rf_write     (rf_write),
    .i_rf_wr_mem    (rf_wr_mem),
    .i_imem_rdata,
    .i_dmem_rdata,
    .i_rf_rdata_x   (rf_rdata_x),
    .i_rf_rdata_y   (rf_rdata_y),
    .o_ir_dc        (ir_dc),
    .o_ir_ex        (ir_ex),
    .o_ir_wr        (ir_wr),
    .o_alu_n        (alu_n),
    .o_alu_z        (alu_z),
    .o_alu_n_imm    (alu_n_imm),
    .o_alu_z_imm    (alu_z_imm),
    .o_pc           (o_imem_addr),
    .o_rf_raddr_x   (rf_raddr_x),
    .o_rf_raddr_y   (rf_raddr_y),
    .o_rf_waddr     (rf_waddr),
    .o_rf_wdata     (rf_wdata),
    .o_dmem_addr,
    .o_dmem_wdata
  );

  cpu_regfile m_cpu_regfile (
    .i_clk,
    .i_rst_n,
    .i_raddr_x (rf_raddr_x),
    .i_raddr_y (rf_raddr_y),
    .i_waddr   (rf_waddr),
    .i_wdata   (rf_wdata),
    .i_we      (rf_write),
    .o_rdata_x (rf_rdata_x),
    .o_rdata_y (rf_rdata_y)
  );

endmodule

/* test/tb_mem.sv */
`timescale 1ns/10ps

module tb_mem (
  input  logic           i_clk,
  input  logic           i_clear,
  input  logic           i_load_en,
  input  cpu_pkg::addr_t i_load_addr,
  input  cpu_pkg::word_t i_load_data,
  input  logic           i_imem_rd,
  input  cpu_pkg::addr_t i_imem_addr,
  output cpu_pkg::word_t o_imem_rdata,
  input  logic           i_dmem_rd,
  input  logic           i_dmem_wr,
  input  cpu_pkg::addr_t i_dmem_addr,
  input  cpu_pkg::word_t i_dmem_wdata,
  output cpu_pkg::word_t o_dmem_rdata
);

  import cpu_pkg::*;

  word_t imem [256];
  word_t dmem [65536];
  addr_t log_addr [$];  // Store log in issue order
  word_t log_data [$];

  // Initial data memory contents depend on the whole address
  function automatic word_t fill_word(input addr_t a);
    return {a[7:0], a[15:8]} ^ 16'hc3a5;
  endfunction

  always @(posedge i_clk) begin
    if (i_clear) begin
      for (int a = 0; a < 256; a++) begin
        imem[a] <= NOP_INSTR;
      end
      for (int a = 0; a < 65536; a++) begin
        dmem[a] <= fill_word(16'(a));
      end
      log_addr.delete();
      log_data.delete();
    end else begin
      if (i_load_en) begin
        imem[i_load_addr[7:0]] <= i_load_data;  // Program space wraps at 256 words
      end
      if (i_dmem_wr) begin
        dmem[i_dmem_addr] <= i_dmem_wdata;
        log_addr.push_back(i_dmem_addr);
        log_data.push_back(i_dmem_wdata);
      end
    end
    if (i_imem_rd) begin
      o_imem_rdata <= imem[i_imem_addr[7:0]];  // One-cycle read latency
    end
    if (i_dmem_rd) begin
      o_dmem_rdata <= dmem[i_dmem_addr];
    end
  end

endmodule

/* test/tb_cpu.sv */
`timescale 1ns/10ps

module tb_cpu;

  import cpu_pkg::*;

  localparam int NUM_TESTS    = 6;
  localparam int PROG_LEN_SUM = 13 + 16 + 11 + 23 + 9 + 1;
  localparam int WATCHDOG_NS  = 4 * (NUM_TESTS * 200 + 4 * PROG_LEN_SUM);

  logic  clk;
  logic  rst_n;
  logic  clear;
  logic  load_en;
  addr_t load_addr;
  word_t load_data;
  logic  imem_rd;
  addr_t imem_addr;
  word_t imem_rdata;
  logic  dmem_rd;
  logic  dmem_wr;
  addr_t dmem_addr;
  word_t dmem_wdata;
  word_t dmem_rdata;
  logic  halted;

  int    mismatches;
  int    other_errors;
  int    halt_errors;
  word_t prog [$];
  addr_t exp_addr [$];
  word_t exp_data [$];

  cpu_top i_dut (
    .i_clk        (clk),
    .i_rst_n      (rst_n),
    .o_imem_rd    (imem_rd),
    .o_imem_addr  (imem_addr),
    .i_imem_rdata (imem_rdata),
    .o_dmem_rd    (dmem_rd),
    .o_dmem_wr    (dmem_wr),
    .o_dmem_addr  (dmem_addr),
    .o_dmem_wdata (dmem_wdata),
    .i_dmem_rdata (dmem_rdata),
    .o_halted     (halted)
  );

  tb_mem i_mem (
    .i_clk        (clk),
    .i_clear      (clear),
    .i_load_en    (load_en),
    .i_load_addr  (load_addr),
    .i_load_data  (load_data),
    .i_imem_rd    (imem_rd),
    .i_imem_addr  (imem_addr),
    .o_imem_rdata (imem_rdata),
    .i_dmem_rd    (dmem_rd),
    .i_dmem_wr    (dmem_wr),
    .i_dmem_addr  (dmem_addr),
    .i_dmem_wdata (dmem_wdata),
    .o_dmem_rdata (dmem_rdata)
  );

  always #2 clk = ~clk;

  // A halted core must stay quiet on both memory ports
  always @(posedge clk) begin
    if (rst_n && halted && (imem_rd || dmem_rd || dmem_wr)) begin
      $display("Memory strobe seen after halt at %0t", $time);
      halt_errors++;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before all tests completed");
    $display("Simulation failed");
    $finish;
  end

  ////////////////////////////////////////////////////
  // Encoding and compare helpers

  function automatic word_t encode_reg(input opcode_t op, input reg_idx_t rx, input reg_idx_t ry);
    return {5'b0, ry, rx, 1'b0, op};
  endfunction

  function automatic word_t encode_imm(input opcode_t op, input reg_idx_t rx,
                                       input logic [7:0] imm);
    return {imm, rx, 1'b0, op};
  endfunction

  function automatic word_t sign_extend(input logic [7:0] b);
    return {{8{b[7]}}, b};
  endfunction

  task automatic compare_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      mismatches++;
    end
  endtask

  task automatic compare_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      mismatches++;
    end
  endtask

  task automatic expect_store(input addr_t a, input word_t d);
    exp_addr.push_back(a);
    exp_data.push_back(d);
  endtask

  ////////////////////////////////////////////////////
  // Program loading and result checks

  task automatic run_program(input string name);
    int cycles;
    @(negedge clk);
    rst_n = 1'b0;
    clear = 1'b1;
    @(negedge clk);
    clear = 1'b0;
    for (int i = 0; i < prog.size(); i++) begin
      load_en   = 1'b1;
      load_addr = addr_t'(i);
      load_data = prog[i];
      @(negedge clk);
    end
    load_en = 1'b0;
    repeat (8) @(negedge clk);
    rst_n  = 1'b1;
    cycles = 0;
    while (!halted && cycles < 100 + 4 * prog.size()) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      $display("%s: core never raised o_halted", name);
      other_errors++;
    end else begin
      repeat (20) @(negedge clk);  // Idle window watched by the halt monitor
    end
  endtask

  task automatic check_stores(input string name);
    int n_got;
    int n_exp;
    n_got = i_mem.log_addr.size();
    n_exp = exp_addr.size();
    for (int i = 0; i < n_got && i < n_exp; i++) begin
      compare_addr($sformatf("%s store %0d o_dmem_addr", name, i), i_mem.log_addr[i], exp_addr[i]);
      compare_word($sformatf("%s store %0d o_dmem_wdata", name, i), i_mem.log_data[i], exp_data[i]);
    end
    if (n_got < n_exp) begin
      $display("%s: only %0d of %0d expected stores appeared", name, n_got, n_exp);
      other_errors++;
    end else if (n_got > n_exp) begin
      $display("%s: %0d stores appeared that should not have", name, n_got - n_exp);
      other_errors++;
    end
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
  endtask

  ////////////////////////////////////////////////////
  // Directed tests

  task automatic test_arith();
    prog.push_back(encode_imm(OP_MVI, 3'd1, 8'd5));
    prog.push_back(encode_imm(OP_MVI, 3'd2, 8'hfd));   // r2 = -3
    prog.push_back(encode_reg(OP_MV, 3'd3, 3'd1));
    prog.push_back(encode_reg(OP_ADD, 3'd3, 3'd2));    // r3 = 5 - 3
    prog.push_back(encode_imm(OP_ADDI, 3'd1, 8'd100));
    prog.push_back(encode_reg(OP_SUB, 3'd2, 3'd1));    // r2 = -3 - 105
    prog.push_back(encode_imm(OP_MVI, 3'd7, 8'h10));
    prog.push_back(encode_reg(OP_ST, 3'd1, 3'd7));
    prog.push_back(encode_imm(OP_ADDI, 3'd7, 8'd1));
    prog.push_back(encode_reg(OP_ST, 3'd2, 3'd7));
    prog.push_back(encode_imm(OP_ADDI, 3'd7, 8'd1));
    prog.push_back(encode_reg(OP_ST, 3'd3, 3'd7));
    prog.push_back(encode_imm(OP_HALT, 3'd0, 8'd0));
    expect_store(16'h0010, 16'd105);
    expect_store(16'h0011, 16'hff94);
    expect_store(16'h0012, 16'd2);
    run_program("arith");
    check_stores("arith");
  endtask

  task automatic test_load_store();
    logic [31:0] rnd;
    word_t       val;
    logic [7:0]  lo;
    logic [7:0]  hi;
    logic [7:0]  a1;
    word_t       diff;
    rnd  = $urandom;
    val  = rnd[15:0];
    rnd  = $urandom;
    a1   = rnd[7:0];
    lo   = val[7:0];
    diff = val - sign_extend(lo);
    hi   = diff[15:8];                                 // Shifted up by eight doublings
    prog.push_back(encode_imm(OP_MVI, 3'd1, hi));
    for (int i = 0; i < 8; i++) begin
      prog.push_back(encode_reg(OP_ADD, 3'd1, 3'd1));
    end
    prog.push_back(encode_imm(OP_ADDI, 3'd1, lo));
    prog.push_back(encode_imm(OP_MVI, 3'd2, a1));
    prog.push_back(encode_reg(OP_ST, 3'd1, 3'd2));
    prog.push_back(encode_reg(OP_LD, 3'd3, 3'd2));
    prog.push_back(encode_imm(OP_MVI, 3'd4, a1 ^ 8'h80));
    prog.push_back(encode_reg(OP_ST, 3'd3, 3'd4));
    prog.push_back(encode_imm(OP_HALT, 3'd0, 8'd0));
    expect_store(sign_extend(a1), val);
    expect_store(sign_extend(a1 ^ 8'h80), val);
    run_program("load_store");
    check_stores("load_store");
  endtask

  task automatic test_forwarding();
    word_t m;
    m = i_mem.fill_word(16'h0020);
    prog.push_back(encode_imm(OP_MVI, 3'd1, 8'd7));
    prog.push_back(encode_imm(OP_MVI, 3'd2, 8'h20));
    prog.push_back(encode_reg(OP_LD, 3'd3, 3'd2));
    prog.push_back(encode_reg(OP_ADD, 3'd3, 3'd1));    // Uses the load result at once
    prog.push_back(encode_imm(OP_ADDI, 3'd3, 8'd3));
    prog.push_back(encode_reg(OP_SUB, 3'd3, 3'd1));
    prog.push_back(encode_reg(OP_ST, 3'd3, 3'd2));
    prog.push_back(encode_reg(OP_MV, 3'd4, 3'd3));
    prog.push_back(encode_reg(OP_ADD, 3'd4, 3'd4));
    prog.push_back(encode_reg(OP_ST, 3'd4, 3'd1));
    prog.push_back(encode_imm(OP_HALT, 3'd0, 8'd0));
    expect_store(16'h0020, m + 16'd3);
    expect_store(16'h0007, (m + 16'd3) + (m + 16'd3));
    run_program("forwarding");
    check_stores("forwarding");
  endtask

  task automatic test_branches();
    prog.push_back(encode_imm(OP_MVI, 3'd1, 8'd5));
    prog.push_back(encode_imm(OP_MVI, 3'd2, 8'd5));
    prog.push_back(encode_imm(OP_MVI, 3'd3, 8'h31));
    prog.push_back(encode_imm(OP_MVI, 3'd4, 8'h3f));   // Wrong-path store address
    prog.push_back(encode_imm(OP_MVI, 3'd5, 8'hff));
    prog.push_back(encode_imm(OP_MVI, 3'd6, 8'h30));
    prog.push_back(encode_imm(OP_MVI, 3'd7, 8'd2));
    prog.push_back(encode_reg(OP_CMP, 3'd1, 3'd2));    // Z set
    prog.push_back(encode_imm(OP_JZ, 3'd0, 8'd3));     // Taken to 11
    prog.push_back(encode_reg(OP_ST, 3'd5, 3'd4));
    prog.push_back(encode_reg(OP_ST, 3'd5, 3'd4));
    prog.push_back(encode_reg(OP_ST, 3'd1, 3'd6));
    prog.push_back(encode_reg(OP_CMP, 3'd1, 3'd2));    // N clear
    prog.push_back(encode_imm(OP_JN, 3'd0, 8'd3));     // Not taken
    prog.push_back(encode_reg(OP_ST, 3'd7, 3'd3));
    prog.push_back(encode_reg(OP_CMP, 3'd7, 3'd1));    // 2 - 5 sets N
    prog.push_back(encode_imm(OP_JN, 3'd0, 8'd3));     // Taken to 19
    prog.push_back(encode_reg(OP_ST, 3'd5, 3'd4));
    prog.push_back(encode_reg(OP_ST, 3'd5, 3'd4));
    prog.push_back(encode_reg(OP_CMP, 3'd7, 3'd1));
    prog.push_back(encode_imm(OP_JZ, 3'd0, 8'd3));     // Not taken
    prog.push_back(encode_reg(OP_ST, 3'd1, 3'd3));
    prog.push_back(encode_imm(OP_HALT, 3'd0, 8'd0));
    expect_store(16'h0030, 16'd5);
    expect_store(16'h0031, 16'd2);
    expect_store(16'h0031, 16'd5);
    run_program("branches");
    check_stores("branches");
  endtask

  task automatic test_jump_register();
    prog.push_back(encode_imm(OP_MVI, 3'd1, 8'd2));
    prog.push_back(encode_imm(OP_ADDI, 3'd1, 8'd4));   // Target address 6
    prog.push_back(encode_imm(OP_MVI, 3'd2, 8'h40));
    prog.push_back(encode_reg(OP_JR, 3'd1, 3'd0));
    prog.push_back(encode_reg(OP_ST, 3'd1, 3'd2));     // Skipped
    prog.push_back(encode_reg(OP_ST, 3'd2, 3'd2));     // Skipped
    prog.push_back(encode_imm(OP_ADDI, 3'd2, 8'd1));
    prog.push_back(encode_reg(OP_ST, 3'd1, 3'd2));
    prog.push_back(encode_imm(OP_HALT, 3'd0, 8'd0));
    expect_store(16'h0041, 16'd6);
    run_program("jump_register");
    check_stores("jump_register");
  endtask

  task automatic test_halt();
    prog.push_back(encode_imm(OP_HALT, 3'd0, 8'd0));
    run_program("halt");
    if (halted !== 1'b1) begin
      $display("halt: o_halted dropped while reset was inactive");
      other_errors++;
    end
    check_stores("halt");
  endtask

  ////////////////////////////////////////////////////
  // Main sequence

  initial begin
    int total;
    clk          = 1'b0;
    rst_n        = 1'b0;
    clear        = 1'b0;
    load_en      = 1'b0;
    load_addr    = '0;
    load_data    = '0;
    mismatches   = 0;
    other_errors = 0;
    halt_errors  = 0;
    void'($urandom(32'hb8bd_243d));
    test_arith();
    test_load_store();
    test_forwarding();
    test_branches();
    test_jump_register();
    test_halt();
    total = mismatches + other_errors + halt_errors;
    $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors + halt_errors);
    if (total == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* files.f */
verilog/cpu_pkg.sv
verilog/cpu_regfile.sv
verilog/cpu_control.sv
verilog/cpu_datapath.sv
verilog/cpu_top.sv
test/tb_mem.sv
test/tb_cpu.sv

/* Makefile */
# Verilator build and run for the pipelined core testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module tb_cpu -Mdir obj_dir -f files.f

# Pass only when the simulation prints the pass message
run: compile
	@out="$$(./obj_dir/Vtb_cpu)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir
